// ==== verification/icache_checker.sv ====
`timescale 1ns/1ps

module icache_checker import icache_op_pkg::*; (
    input logic          clk,
    input logic          rstn,
    input logic          req_ready,
    input logic          rdata_valid,
    input logic          mem_req,
    input logic          mem_addr_ok,
    input icache_state_e state
);

    int violations = 0;

    // request must wait for the memory to take the address
    mem_req_held: assert property (
        @(posedge clk) disable iff (!rstn) (mem_req && !mem_addr_ok) |=> mem_req
    ) else begin
        violations++;
        $error("mem_req dropped before mem_addr_ok");
    end

    no_result_in_idle: assert property (
        @(posedge clk) disable iff (!rstn) (state == idle) |-> !rdata_valid
    ) else begin
        violations++;
        $error("rdata_valid high in the idle state");
    end

    // rstn rose during the previous cycle
    ready_low_after_reset: assert property (
        @(posedge clk) $rose(rstn) |-> !req_ready
    ) else begin
        violations++;
        $error("req_ready high in the first cycle after reset");
    end

endmodule

bind icache_top icache_checker checker_i (
    .clk, .rstn, .req_ready, .rdata_valid, .mem_req, .mem_addr_ok, .state(fsm_i.state)
);

// ==== verification/icache_input.dat ====
// columns: kind (0 fetch, 1 uncached, 2 cache op, 3 flushed fetch), address, opcode,
// expected word, expected memory requests; a kind of f ends the list
0 00000010 00000000 a5a50010 1
0 0000001c 00000000 a5a5001c 0
0 00000014 00000000 a5a50014 0
0 00000020 00000000 a5a50020 1
0 00000120 00000000 a5a50120 1
0 00000024 00000000 a5a50024 0
0 00000228 00000000 a5a50228 1
0 0000002c 00000000 a5a5002c 0
0 00000124 00000000 a5a50124 1
1 00000034 00000000 a5a50034 1
1 00000034 00000000 a5a50034 1
0 00000030 00000000 a5a50030 1
0 00000040 00000000 a5a50040 1
2 00000040 00000008 00000000 0
0 00000048 00000000 a5a50048 1
0 00000050 00000000 a5a50050 1
2 00000054 00000010 00000000 0
0 00000050 00000000 a5a50050 1
0 00000060 00000000 a5a50060 1
2 00000060 00000000 00000000 0
0 0000006c 00000000 a5a5006c 1
0 00000070 00000000 a5a50070 1
2 00000070 80000000 00000000 0
0 00000074 00000000 a5a50074 0
3 00000080 00000000 00000000 0
0 00000080 00000000 a5a50080 1
3 00000084 00000000 00000000 0
0 00000088 00000000 a5a50088 0
f 00000000 00000000 00000000 0

// ==== verification/icache_tb.sv ====
`timescale 1ns/1ps

module icache_tb import icache_cfg_pkg::*; ();

    localparam int    max_steps  = 64;
    localparam int    step_words = 5;   // kind, address, opcode, word, requests
    localparam word_t pattern    = 32'hA5A5_0000;

    logic  clk, rstn;
    logic  req_valid, req_ready, req_uncached, req_is_op, flush, rdata_valid;
    addr_t req_addr, mem_addr;
    word_t req_opcode, rdata;
    logic  mem_req, mem_addr_ok, mem_data_ok;
    line_t mem_rline;

    logic [31:0] step_mem [max_steps*step_words];
    int          num_steps;
    int          error_count;
    int          failed_steps;
    int          mem_requests;
    logic        load_done = 1'b0;

    tb_clock_gen #(.period(40), .reset_cycles(2)) clock_gen_i (.clk, .rstn);

    icache_top dut_i (
        .clk, .rstn, .req_valid, .req_ready, .req_addr, .req_uncached, .req_is_op,
        .req_opcode, .flush, .rdata, .rdata_valid, .mem_req, .mem_addr, .mem_addr_ok,
        .mem_data_ok, .mem_rline
    );

    // each word holds its own byte address with a fixed pattern on top
    function automatic line_t line_from(input addr_t base);
        line_t line;
        for (int i = 0; i < 4; i++) begin
            line[i*32 +: 32] = (base + addr_t'(4 * i)) ^ pattern;
        end
        return line;
    endfunction

    task automatic check_value(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // memory model
    //////////////////////////////////////////////////////////////////////

    initial begin : memory_model
        addr_t base;
        int    addr_delay;
        int    data_delay;
        int    seed_draw;
        mem_addr_ok  = 1'b0;
        mem_data_ok  = 1'b0;
        mem_rline    = '0;
        mem_requests = 0;
        seed_draw    = $urandom(32'h427b7afe);
        forever begin
            @(posedge clk);
            #1;   // look before the stimulus moves
            if (mem_req) begin
                mem_requests++;
                // line address for a cached miss, word address when uncached
                check_value(mem_addr, req_uncached ? {req_addr[31:2], 2'b00}
                                                   : {req_addr[31:4], 4'b0000}, "mem_addr");
                base       = {mem_addr[31:4], 4'b0000};
                addr_delay = $urandom % 4;
                data_delay = $urandom % 4;
                #1;
                repeat (addr_delay) begin
                    @(posedge clk);
                    #2;
                end
                mem_addr_ok = 1'b1;
                @(posedge clk);
                #2;
                mem_addr_ok = 1'b0;
                repeat (data_delay) begin
                    @(posedge clk);
                    #2;
                end
                mem_data_ok = 1'b1;   // whole line in one beat
                mem_rline   = line_from(base);
                @(posedge clk);
                #2;
                mem_data_ok = 1'b0;
            end
        end
    end

    initial begin : watchdog
        wait (load_done);
        repeat ((num_steps + 1) * 20) @(posedge clk);
        $display("simulation timed out after %0d cycles", (num_steps + 1) * 20);
        $display("tests failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // test steps
    //////////////////////////////////////////////////////////////////////

    task automatic check_reset();
        int errs_before;
        errs_before = error_count;
        @(negedge clk);
        check_value(req_ready, 1'b0, "req_ready in reset");
        wait (rstn === 1'b1);
        @(negedge clk);
        check_value(req_ready, 1'b0, "req_ready in the first cycle after reset");
        @(negedge clk);
        check_value(req_ready, 1'b1, "req_ready after reset");
        if (error_count != errs_before) failed_steps++;
        $display("reset: %s", (error_count == errs_before) ? "ok" : "mismatch");
    endtask

    task automatic run_step(input int n);
        word_t kind;
        word_t exp_word;
        word_t got_word;
        int    exp_reqs;
        int    got_valid;
        int    reqs_before;
        int    errs_before;
        logic  done;
        kind        = step_mem[n*step_words];
        exp_word    = step_mem[n*step_words+3];
        exp_reqs    = int'(step_mem[n*step_words+4]);
        got_word    = '0;
        got_valid   = 0;
        done        = 1'b0;
        reqs_before = mem_requests;
        errs_before = error_count;
        @(posedge clk);
        #2;
        req_valid    = 1'b1;
        req_addr     = step_mem[n*step_words+1];
        req_opcode   = step_mem[n*step_words+2];
        req_uncached = (kind == 1);
        req_is_op    = (kind == 2);
        flush        = (kind == 3);   // held on through the lookup cycle
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        req_valid = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (rdata_valid) begin
                got_valid++;
                got_word = rdata;
            end
            if (req_ready) begin
                done = 1'b1;
            end else if (flush) begin
                @(posedge clk);
                #2;
                flush = 1'b0;
            end
        end
        check_value(got_valid, (kind < 2) ? 1 : 0, "rdata_valid pulses");
        if (kind < 2) check_value(got_word, exp_word, "rdata");
        check_value(mem_requests - reqs_before, exp_reqs, "memory requests");
        if (error_count != errs_before) failed_steps++;
        $display("step %0d kind %0d addr %h: %s", n, kind, req_addr,
                 (error_count == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin : main
        int n;
        req_valid    = 1'b0;
        req_addr     = '0;
        req_uncached = 1'b0;
        req_is_op    = 1'b0;
        req_opcode   = '0;
        flush        = 1'b0;
        error_count  = 0;
        failed_steps = 0;
        num_steps    = 0;
        for (int i = 0; i < max_steps * step_words; i++) begin
            step_mem[i] = '1;
        end
        $readmemh("verification/icache_input.dat", step_mem);
        while (num_steps < max_steps && step_mem[num_steps*step_words] < 4) begin
            num_steps++;
        end
        load_done = 1'b1;
        check_reset();
        for (n = 0; n < num_steps; n++) begin
            run_step(n);
        end
        if (num_steps == 0) $display("no test steps were found in the data file");
        $display("steps run %0d, with errors %0d, check errors %0d, assertion errors %0d",
                 num_steps + 1, failed_steps, error_count, dut_i.checker_i.violations);
        if (num_steps > 0 && error_count == 0 && dut_i.checker_i.violations == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period       = 40,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #2;
        rstn = 1'b1;   // released off the edge like the other inputs
    end

endmodule

// ==== verilog.f ====
verilog/icache_cfg_pkg.sv
verilog/icache_op_pkg.sv
verilog/icache_req_buf.sv
verilog/icache_tagv_array.sv
verilog/icache_data_lru.sv
verilog/icache_fsm.sv
verilog/icache_top.sv
verification/tb_clock_gen.sv
verification/icache_checker.sv
verification/icache_tb.sv

// ==== verilog/icache_cfg_pkg.sv ====
package icache_cfg_pkg;

    //////////////////////////////////////////////////////////////////////
    // basic widths
    //////////////////////////////////////////////////////////////////////

    localparam int ADDR_WIDTH = 32;
    localparam int WORD_WIDTH = 32;
    localparam int LINE_WORDS = 4;   // one refill beat carries the whole line

    typedef logic [ADDR_WIDTH-1:0]            addr_t;  // byte address
    typedef logic [WORD_WIDTH-1:0]            word_t;  // one instruction
    typedef logic [LINE_WORDS*WORD_WIDTH-1:0] line_t;  // word 0 in the low bits

    //////////////////////////////////////////////////////////////////////
    // default geometry
    //////////////////////////////////////////////////////////////////////

    // 16 sets of 4 words per way, 2 ways
    localparam int DEF_INDEX_WIDTH  = 4;
    localparam int DEF_OFFSET_WIDTH = 2;   // word offset, not byte offset

endpackage

// ==== verilog/icache_data_lru.sv ====
`timescale 1ns/1ps

module icache_data_lru import icache_cfg_pkg::*; #(
    parameter int index_width  = 4,
    parameter int offset_width = 2
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic [index_width-1:0]  rd_index,
    input  logic [index_width-1:0]  buf_index,
    input  logic [offset_width-1:0] buf_offset,
    input  logic [1:0]              hit_way,
    input  logic                    fill_we,
    input  line_t                   refill_line,
    input  logic                    use_hit,
    input  logic                    use_fill,
    output logic                    victim_way,
    output word_t                   rdata
);

    localparam int sets = 1 << index_width;

    line_t           data_mem [2][sets];
    line_t           rd_line [2];
    logic [sets-1:0] lru_q;         // per set, the way to replace next
    logic [1:0]      data_we;
    line_t           hit_line;
    word_t           hit_word;
    word_t           fill_word;

    assign victim_way = lru_q[buf_index];
    assign data_we    = fill_we ? (victim_way ? 2'b10 : 2'b01) : 2'b00;

    //////////////////////////////////////////////////////////////////////
    // line storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (data_we[w]) data_mem[w][buf_index] <= refill_line;
            rd_line[w] <= (data_we[w] && rd_index == buf_index) ? refill_line
                                                               : data_mem[w][rd_index];
        end
    end

    // other way becomes the victim after each use
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lru_q <= '0;
        end else if (fill_we) begin
            lru_q[buf_index] <= ~victim_way;
        end else if (use_hit) begin
            lru_q[buf_index] <= hit_way[0];   // hit in way 0 leaves way 1 as victim
        end
    end

    // result word
    assign hit_line  = hit_way[1] ? rd_line[1] : rd_line[0];
    assign hit_word  = hit_line[buf_offset*$bits(word_t) +: $bits(word_t)];
    assign fill_word = refill_line[buf_offset*$bits(word_t) +: $bits(word_t)];
    assign rdata     = use_fill ? fill_word : hit_word;

endmodule

// ==== verilog/icache_fsm.sv ====
`timescale 1ns/1ps

module icache_fsm import icache_op_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        req_valid,
    input  logic        flush,
    input  logic        hit,
    input  logic [1:0]  hit_way,
    input  logic        buf_uncached,
    input  logic        buf_is_op,
    input  logic        buf_is_ibar,
    input  cacop_kind_e buf_kind,
    input  logic        buf_way_sel,
    input  logic        victim_way,
    input  logic        mem_addr_ok,
    input  logic        mem_data_ok,
    output logic        req_ready,
    output logic        capture,
    output logic        rdata_valid,
    output logic        mem_req,
    output logic        fill_we,
    output logic        fill_way,
    output logic        inval_we,
    output logic        inval_way,
    output logic        init_we,
    output logic        init_way,
    output logic        use_hit,
    output logic        use_fill
);

    icache_state_e state;
    icache_state_e next_state;
    logic          rst_done;   // low in the first cycle after reset
    logic          ready_raw;
    logic          miss;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) rst_done <= 1'b0;
        else       rst_done <= 1'b1;
    end

    assign req_ready = ready_raw & rst_done;
    assign capture   = req_valid & req_ready;
    assign miss      = ~hit | buf_uncached;   // uncached always goes out
    assign fill_way  = victim_way;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) state <= idle;
        else       state <= next_state;
    end

    //////////////////////////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////////////////////////

    // the flush state is written with its package scope, the bare name is the port
    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (capture) next_state = lookup;
            end
            lookup: begin
                if (flush) begin
                    next_state = icache_op_pkg::flush;
                end else if (buf_is_op) begin
                    next_state = operation;
                end else if (miss) begin
                    next_state = mem_addr_ok ? miss_wait : miss_req;   // skip miss_req
                end else if (!capture) begin
                    next_state = idle;   // hit with nothing behind it
                end
            end
            miss_req: begin
                if (mem_addr_ok) next_state = miss_wait;
            end
            miss_wait: begin
                if (mem_data_ok) next_state = capture ? lookup : idle;
            end
            operation: begin
                if (flush) next_state = icache_op_pkg::flush;
                else       next_state = capture ? lookup : idle;
            end
            icache_op_pkg::flush: begin
                if (!flush) next_state = capture ? lookup : idle;
            end
            default: next_state = idle;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        ready_raw   = 1'b0;
        rdata_valid = 1'b0;
        mem_req     = 1'b0;
        fill_we     = 1'b0;
        inval_we    = 1'b0;
        inval_way   = buf_way_sel;
        init_we     = 1'b0;
        init_way    = buf_way_sel;
        use_hit     = 1'b0;
        use_fill    = 1'b0;
        case (state)
            idle: ready_raw = 1'b1;
            lookup: begin
                if (!flush && !buf_is_op) begin
                    if (miss) begin
                        mem_req = 1'b1;
                    end else begin
                        rdata_valid = 1'b1;
                        use_hit     = 1'b1;
                        ready_raw   = 1'b1;   // back-to-back hits
                    end
                end
            end
            miss_req: mem_req = 1'b1;   // held until mem_addr_ok
            miss_wait: begin
                if (mem_data_ok) begin
                    rdata_valid = 1'b1;
                    use_fill    = 1'b1;
                    ready_raw   = 1'b1;
                    fill_we     = ~buf_uncached;
                end
            end
            operation: begin
                if (!flush) begin
                    ready_raw = 1'b1;
                    if (!buf_is_ibar) begin   // barrier touches nothing
                        case (buf_kind)
                            index_init:  init_we  = 1'b1;
                            index_inval: inval_we = 1'b1;
                            hit_inval: begin
                                inval_we  = hit;
                                inval_way = hit_way[1];
                            end
                            default: ;
                        endcase
                    end
                end
            end
            icache_op_pkg::flush: ready_raw = ~flush;
            default: ;
        endcase
    end

endmodule

// ==== verilog/icache_op_pkg.sv ====
package icache_op_pkg;

    //////////////////////////////////////////////////////////////////////
    // cache operations
    //////////////////////////////////////////////////////////////////////

    // kind field of the opcode, ignored for a barrier
    typedef enum logic [1:0] {
        index_init  = 2'd0,   // clear tag and valid of the way picked by addr[0]
        index_inval = 2'd1,   // clear valid of the way picked by addr[0]
        hit_inval   = 2'd2    // clear valid of the way that hits
    } cacop_kind_e;

    localparam int OP_IBAR_BIT = 31;   // set means instruction barrier
    localparam int OP_KIND_LSB = 3;    // kind sits in opcode[4:3]

    //////////////////////////////////////////////////////////////////////
    // control states
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        idle,        // waiting for a request
        lookup,      // tags compared, hit returned here
        miss_req,    // mem_req up, waiting for mem_addr_ok
        miss_wait,   // waiting for mem_data_ok
        operation,   // cache op, one cycle
        flush        // pipeline flush, held while flush is high
    } icache_state_e;

endpackage

// ==== verilog/icache_req_buf.sv ====
`timescale 1ns/1ps

module icache_req_buf import icache_cfg_pkg::*; import icache_op_pkg::*; #(
    parameter  int index_width  = 4,
    parameter  int offset_width = 2,
    localparam int tag_width    = 32 - index_width - offset_width - 2
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    capture,
    input  addr_t                   req_addr,
    input  logic                    req_uncached,
    input  logic                    req_is_op,
    input  word_t                   req_opcode,
    output logic [tag_width-1:0]    buf_tag,
    output logic [index_width-1:0]  buf_index,
    output logic [offset_width-1:0] buf_offset,
    output logic                    buf_uncached,
    output logic                    buf_is_op,
    output logic                    buf_is_ibar,
    output cacop_kind_e             buf_kind,
    output logic                    buf_way_sel,
    output addr_t                   buf_line_addr
);

    addr_t       addr_q;
    logic        uncached_q;
    logic        is_op_q;
    logic        is_ibar_q;
    cacop_kind_e kind_q;

    always_ff @(posedge clk) begin
        if (capture) addr_q <= req_addr;
    end

    // opcode decoded on the way in
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            uncached_q <= 1'b0;
            is_op_q    <= 1'b0;
            is_ibar_q  <= 1'b0;
            kind_q     <= index_init;
        end else if (capture) begin
            uncached_q <= req_uncached & ~req_is_op;  // ops never go to memory
            is_op_q    <= req_is_op;
            is_ibar_q  <= req_is_op & req_opcode[OP_IBAR_BIT];
            kind_q     <= cacop_kind_e'(req_opcode[OP_KIND_LSB +: 2]);
        end
    end

    // address split: tag | index | word offset | byte
    assign buf_tag       = addr_q[31 -: tag_width];
    assign buf_index     = addr_q[offset_width+2 +: index_width];
    assign buf_offset    = addr_q[2 +: offset_width];
    assign buf_way_sel   = addr_q[0];   // way for the index ops
    assign buf_line_addr = {addr_q[31:offset_width+2], {(offset_width+2){1'b0}}};

    assign buf_uncached  = uncached_q;
    assign buf_is_op     = is_op_q;
    assign buf_is_ibar   = is_ibar_q;
    assign buf_kind      = kind_q;

endmodule

// ==== verilog/icache_tagv_array.sv ====
`timescale 1ns/1ps

module icache_tagv_array #(
    parameter  int index_width  = 4,
    parameter  int offset_width = 2,
    localparam int tag_width    = 32 - index_width - offset_width - 2
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [index_width-1:0] rd_index,
    input  logic [tag_width-1:0]   cmp_tag,
    input  logic                   fill_we,
    input  logic                   fill_way,
    input  logic                   inval_we,
    input  logic                   inval_way,
    input  logic [index_width-1:0] inval_index,
    input  logic                   init_we,
    input  logic                   init_way,
    output logic [1:0]             hit_way,
    output logic                   hit
);

    localparam int sets = 1 << index_width;

    logic [tag_width-1:0]  tag_mem [2][sets];
    logic [1:0][sets-1:0]  valid_q;
    logic [tag_width-1:0]  rd_tag [2];
    logic [1:0]            rd_valid;
    logic [1:0]            tag_we;
    logic [1:0]            valid_we;
    logic [tag_width-1:0]  wr_tag;
    logic                  wr_valid;
    logic                  same_row;

    //////////////////////////////////////////////////////////////////////
    // write side, all writes go to the buffered index
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        wr_tag   = init_we ? '0 : cmp_tag;
        wr_valid = fill_we & ~inval_we & ~init_we;   // only a refill sets valid
        for (int w = 0; w < 2; w++) begin
            tag_we[w]   = (fill_we && fill_way == 1'(w)) || (init_we && init_way == 1'(w));
            valid_we[w] = tag_we[w] || (inval_we && inval_way == 1'(w));
        end
    end

    assign same_row = (rd_index == inval_index);

    //////////////////////////////////////////////////////////////////////
    // storage and registered read, new data forwarded on a same-row write
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (tag_we[w]) tag_mem[w][inval_index] <= wr_tag;
            rd_tag[w] <= (tag_we[w] && same_row) ? wr_tag : tag_mem[w][rd_index];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q  <= '0;
            rd_valid <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (valid_we[w]) valid_q[w][inval_index] <= wr_valid;
                rd_valid[w] <= (valid_we[w] && same_row) ? wr_valid
                                                         : valid_q[w][rd_index];
            end
        end
    end

    // compare against the tag of the request in flight
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit_way[w] = rd_valid[w] && (rd_tag[w] == cmp_tag);
        end
    end

    assign hit = |hit_way;

endmodule

// ==== verilog/icache_top.sv ====
`timescale 1ns/1ps

module icache_top import icache_cfg_pkg::*, icache_op_pkg::*; #(
    parameter  int index_width  = DEF_INDEX_WIDTH,
    parameter  int offset_width = DEF_OFFSET_WIDTH,
    localparam int tag_width    = 32 - index_width - offset_width - 2
) (
    input  logic  clk,
    input  logic  rstn,
    // pipeline side
    input  logic  req_valid,
    output logic  req_ready,
    input  addr_t req_addr,
    input  logic  req_uncached,
    input  logic  req_is_op,
    input  word_t req_opcode,
    input  logic  flush,
    output word_t rdata,
    output logic  rdata_valid,
    // memory side
    output logic  mem_req,
    output addr_t mem_addr,
    input  logic  mem_addr_ok,
    input  logic  mem_data_ok,
    input  line_t mem_rline
);

    logic                    capture;
    logic [tag_width-1:0]    buf_tag;
    logic [index_width-1:0]  buf_index;
    logic [offset_width-1:0] buf_offset;
    logic                    buf_uncached;
    logic                    buf_is_op;
    logic                    buf_is_ibar;
    cacop_kind_e             buf_kind;
    logic                    buf_way_sel;
    addr_t                   buf_line_addr;
    logic [index_width-1:0]  rd_index;
    logic [1:0]              hit_way;
    logic                    hit;
    logic                    fill_we, fill_way;
    logic                    inval_we, inval_way;
    logic                    init_we, init_way;
    logic                    use_hit, use_fill;
    logic                    victim_way;

    // new request's set on acceptance, else keep reading the buffered set
    assign rd_index = capture ? req_addr[offset_width+2 +: index_width] : buf_index;
    assign mem_addr = buf_uncached ? {buf_tag, buf_index, buf_offset, 2'b00} : buf_line_addr;

    icache_req_buf #(.index_width(index_width), .offset_width(offset_width)) req_buf_i (
        .clk, .rstn, .capture, .req_addr, .req_uncached, .req_is_op, .req_opcode,
        .buf_tag, .buf_index, .buf_offset, .buf_uncached, .buf_is_op, .buf_is_ibar,
        .buf_kind, .buf_way_sel, .buf_line_addr
    );

    icache_tagv_array #(.index_width(index_width), .offset_width(offset_width)) tagv_i (
        .clk, .rstn, .rd_index, .cmp_tag(buf_tag), .fill_we, .fill_way, .inval_we,
        .inval_way, .inval_index(buf_index), .init_we, .init_way, .hit_way, .hit
    );

    icache_data_lru #(.index_width(index_width), .offset_width(offset_width)) data_lru_i (
        .clk, .rstn, .rd_index, .buf_index, .buf_offset, .hit_way, .fill_we,
        .refill_line(mem_rline), .use_hit, .use_fill, .victim_way, .rdata
    );

    icache_fsm fsm_i (
        .clk, .rstn, .req_valid, .flush, .hit, .hit_way, .buf_uncached, .buf_is_op,
        .buf_is_ibar, .buf_kind, .buf_way_sel, .victim_way, .mem_addr_ok, .mem_data_ok,
        .req_ready, .capture, .rdata_valid, .mem_req, .fill_we, .fill_way, .inval_we,
        .inval_way, .init_we, .init_way, .use_hit, .use_fill
    );

endmodule
